// ==== verilog/ccu_pkg.sv ====
`default_nettype none

package ccu_pkg;

    // ==========================================================
    // Widths and counts
    // ==========================================================
    localparam int ISA_WORD_W  = 128;
    localparam int OPCODE_W    = 8;
    localparam int PAYLOAD_W   = ISA_WORD_W - OPCODE_W;   // 120
    localparam int ADDR_W      = 16;
    localparam int UNIT_IDX_W  = 2;
    localparam int WORD_CNT_W  = ADDR_W - UNIT_IDX_W;      // 14
    localparam int NUM_UNIT    = 3;
    localparam int IDX_W       = 16;
    localparam int CHN_W       = 12;
    localparam int ACT_W       = 8;
    localparam int K_W         = 6;
    localparam int DRAM_ADDR_W = 32;
    localparam int NUM_LAYER_W = 20;
    localparam int BEAT_IDX_W  = 1;                        // Enough for two words

    // Words per configuration
    localparam int WORDS_CCU   = 1;
    localparam int WORDS_KNN   = 1;
    localparam int WORDS_SYA   = 2;

    // ==========================================================
    // Enums
    // ==========================================================
    typedef enum logic [2:0] {
        IDLE, ARB, FETCH, DELIVER, NET_DONE
    } ccu_state_e;

    // Value is also unit index and priority, lowest wins
    typedef enum logic [OPCODE_W-1:0] {
        OP_CCU = 8'd0,
        OP_KNN = 8'd1,
        OP_SYA = 8'd2
    } ccu_opcode_e;

    // ==========================================================
    // Instruction and configuration layouts
    // ==========================================================
    typedef struct packed {
        logic [PAYLOAD_W-1:0] payload;
        logic [OPCODE_W-1:0]  opcode;    // Raw, may be foreign
    } isa_word_t;

    typedef struct packed {
        logic [PAYLOAD_W-NUM_LAYER_W-1:0] pad;
        logic [NUM_LAYER_W-1:0]           num_layer;
    } ccu_word_t;

    typedef struct packed {
        logic [IDX_W-1:0] map_wr_addr;
        logic [IDX_W-1:0] crd_rd_addr;
        logic [K_W-1:0]   k;
        logic [IDX_W-1:0] nip;           // Input point count
    } knn_cfg_t;

    typedef struct packed {
        logic [ADDR_W-1:0] ofm_wr_base;
        logic [ADDR_W-1:0] wgt_rd_base;
        logic [ADDR_W-1:0] act_rd_base;
        logic              lop_ord;
        logic [CHN_W-1:0]  num_til_ifm;
        logic [CHN_W-1:0]  num_til_flt;
        logic [CHN_W-1:0]  grp_per_tile;
        logic [CHN_W-1:0]  chn;
        logic [1:0]        mode;
        logic [ACT_W-1:0]  zp;
        logic [ACT_W-1:0]  shift;
    } sya_word0_t;

    typedef struct packed {
        logic [DRAM_ADDR_W-1:0] ofm_dram_base;
        logic [DRAM_ADDR_W-1:0] act_dram_base;
    } sya_word1_t;

    typedef struct packed {
        sya_word1_t w1;
        sya_word0_t w0;
    } sya_cfg_t;

    // Matching word handed from fetch to decoder
    typedef struct packed {
        ccu_opcode_e           opcode;
        logic [BEAT_IDX_W-1:0] word_idx;
        logic                  last;
        logic [PAYLOAD_W-1:0]  payload;
    } isa_beat_t;

endpackage

`default_nettype wire

// ==== verilog/ccu_sequencer.sv ====
`default_nettype none

module ccu_sequencer (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            start_i,
    input  wire logic                            knn_rdy_i,
    input  wire logic                            sya_rdy_i,
    input  wire logic                            last_beat_i,
    input  wire logic                            cfg_done_i,
    input  wire logic [ccu_pkg::NUM_LAYER_W-1:0] cfg_num_layer_i,
    output logic                                 fetch_en_o,
    output ccu_pkg::ccu_opcode_e                 sel_unit_o,
    output logic                                 units_rst_o,
    output logic                                 net_done_o
);

    ccu_pkg::ccu_state_e             state_q;
    ccu_pkg::ccu_state_e             state_d;
    ccu_pkg::ccu_opcode_e            sel_q;
    ccu_pkg::ccu_opcode_e            grant;
    logic                            self_rdy_q;
    logic [ccu_pkg::NUM_UNIT-1:0]    req;
    logic [ccu_pkg::NUM_LAYER_W-1:0] layer_cnt_q;
    logic                            sya_done;
    logic                            net_last;

    assign req = {sya_rdy_i, knn_rdy_i, self_rdy_q};

    // Fixed priority, lowest index wins
    always_comb begin
        grant = sel_q;
        for (int i = ccu_pkg::NUM_UNIT - 1; i >= 0; i--) begin
            if (req[i]) begin
                grant = ccu_pkg::ccu_opcode_e'(i);
            end
        end
    end

    assign sya_done = cfg_done_i && (sel_q == ccu_pkg::OP_SYA);
    assign net_last = (layer_cnt_q + 1'b1 == cfg_num_layer_i) && (cfg_num_layer_i != '0);

    // ==========================================================
    // FSM
    // ==========================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ccu_pkg::IDLE: begin
                if (start_i) begin
                    state_d = ccu_pkg::ARB;
                end
            end
            ccu_pkg::ARB: begin
                if (|req) begin
                    state_d = ccu_pkg::FETCH;
                end
            end
            ccu_pkg::FETCH: begin
                if (last_beat_i) begin
                    state_d = ccu_pkg::DELIVER;
                end
            end
            ccu_pkg::DELIVER: begin
                if (sya_done && net_last) begin
                    state_d = ccu_pkg::NET_DONE;
                end else if (cfg_done_i) begin
                    state_d = ccu_pkg::ARB;
                end
            end
            default: state_d = ccu_pkg::IDLE;   // NET_DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ccu_pkg::IDLE;
            sel_q       <= ccu_pkg::OP_CCU;
            self_rdy_q  <= 1'b1;
            layer_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ccu_pkg::ARB && |req) begin
                sel_q <= grant;
            end
            // Own word is wanted once per network
            if (state_q == ccu_pkg::IDLE) begin
                self_rdy_q <= 1'b1;
            end else if (state_q == ccu_pkg::ARB && |req && grant == ccu_pkg::OP_CCU) begin
                self_rdy_q <= 1'b0;
            end
            if (state_q == ccu_pkg::IDLE) begin
                layer_cnt_q <= '0;
            end else if (state_q == ccu_pkg::DELIVER && sya_done) begin
                layer_cnt_q <= layer_cnt_q + 1'b1;   // One layer per SYA config
            end
        end
    end

    assign fetch_en_o  = (state_q == ccu_pkg::FETCH);
    assign sel_unit_o  = sel_q;
    assign units_rst_o = (state_q == ccu_pkg::IDLE);
    assign net_done_o  = (state_q == ccu_pkg::NET_DONE);

endmodule

`default_nettype wire

// ==== verilog/ccu_isa_fetch.sv ====
`default_nettype none

module ccu_isa_fetch (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       fetch_en_i,
    input  wire ccu_pkg::ccu_opcode_e       sel_unit_i,
    input  wire logic                       clear_i,
    output logic [ccu_pkg::ADDR_W-1:0]      isa_addr_o,
    output logic                            isa_addr_vld_o,
    input  wire logic                       isa_addr_rdy_i,
    input  wire ccu_pkg::isa_word_t         isa_dat_i,
    input  wire logic                       isa_dat_vld_i,
    output logic                            isa_dat_rdy_o,
    output ccu_pkg::isa_beat_t              beat_o,
    output logic                            beat_vld_o,
    output logic [ccu_pkg::ADDR_W-1:0]      isa_rd_addr_min_o
);

    logic [ccu_pkg::WORD_CNT_W-1:0] word_cnt_q [ccu_pkg::NUM_UNIT];
    logic [ccu_pkg::ADDR_W-1:0]     unit_addr  [ccu_pkg::NUM_UNIT];
    logic [ccu_pkg::ADDR_W-1:0]     min_addr;
    logic [ccu_pkg::OPCODE_W-1:0]   sel_code;
    logic [ccu_pkg::UNIT_IDX_W-1:0] sel_idx;
    logic [ccu_pkg::BEAT_IDX_W-1:0] word_idx_q;
    logic                           pending_q;
    logic                           addr_hs;
    logic                           dat_hs;
    logic                           match;
    logic                           last_word;
    int                             words_sel;

    assign sel_code = sel_unit_i;
    assign sel_idx  = sel_code[ccu_pkg::UNIT_IDX_W-1:0];

    // ==========================================================
    // Per-unit address counters
    // ==========================================================
    always_comb begin
        for (int u = 0; u < ccu_pkg::NUM_UNIT; u++) begin
            unit_addr[u] = {u[ccu_pkg::UNIT_IDX_W-1:0], word_cnt_q[u]};
        end
    end

    // Skipped words advance the counter too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int u = 0; u < ccu_pkg::NUM_UNIT; u++) begin
                word_cnt_q[u] <= '0;
            end
        end else if (clear_i) begin
            for (int u = 0; u < ccu_pkg::NUM_UNIT; u++) begin
                word_cnt_q[u] <= '0;
            end
        end else if (addr_hs) begin
            word_cnt_q[sel_idx] <= word_cnt_q[sel_idx] + 1'b1;
        end
    end

    // Lowest address still needed by any unit
    always_comb begin
        min_addr = unit_addr[0];
        for (int u = 1; u < ccu_pkg::NUM_UNIT; u++) begin
            if (unit_addr[u] < min_addr) begin
                min_addr = unit_addr[u];
            end
        end
    end
    assign isa_rd_addr_min_o = min_addr;

    // ==========================================================
    // Read control, one read in flight
    // ==========================================================
    assign isa_addr_o     = unit_addr[sel_idx];
    assign isa_addr_vld_o = fetch_en_i & ~pending_q;
    assign isa_dat_rdy_o  = pending_q;
    assign addr_hs        = isa_addr_vld_o & isa_addr_rdy_i;
    assign dat_hs         = isa_dat_vld_i & pending_q;
    assign match          = dat_hs & (isa_dat_i.opcode == sel_code);

    always_comb begin
        case (sel_unit_i)
            ccu_pkg::OP_KNN: words_sel = ccu_pkg::WORDS_KNN;
            ccu_pkg::OP_SYA: words_sel = ccu_pkg::WORDS_SYA;
            default:         words_sel = ccu_pkg::WORDS_CCU;
        endcase
    end
    assign last_word = (word_idx_q == words_sel - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q  <= 1'b0;
            word_idx_q <= '0;
        end else begin
            if (addr_hs) begin
                pending_q <= 1'b1;
            end else if (dat_hs) begin
                pending_q <= 1'b0;
            end
            if (!fetch_en_i) begin          // Restart per configuration
                word_idx_q <= '0;
            end else if (match) begin
                if (last_word) begin
                    word_idx_q <= '0;
                end else begin
                    word_idx_q <= word_idx_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        beat_o.opcode   = sel_unit_i;
        beat_o.word_idx = word_idx_q;
        beat_o.last     = last_word;
        beat_o.payload  = isa_dat_i.payload;
    end
    assign beat_vld_o = match;

endmodule

`default_nettype wire

// ==== verilog/ccu_cfg_decoder.sv ====
`default_nettype none

module ccu_cfg_decoder (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire ccu_pkg::isa_beat_t           beat_i,
    input  wire logic                         beat_vld_i,
    output ccu_pkg::knn_cfg_t                 knn_cfg_o,
    output logic                              knn_cfg_vld_o,
    input  wire logic                         knn_cfg_rdy_i,
    output ccu_pkg::sya_cfg_t                 sya_cfg_o,
    output logic                              sya_cfg_vld_o,
    input  wire logic                         sya_cfg_rdy_i,
    output logic [ccu_pkg::NUM_LAYER_W-1:0]   cfg_num_layer_o,
    output logic                              cfg_done_o
);

    ccu_pkg::ccu_word_t  ccu_word;
    ccu_pkg::knn_cfg_t   knn_word;
    ccu_pkg::sya_word0_t sya_word0;
    ccu_pkg::sya_word1_t sya_word1;
    logic                is_ccu;
    logic                is_knn;
    logic                is_sya;
    logic                knn_hs;
    logic                sya_hs;
    logic                ccu_done_q;

    // ==========================================================
    // Payload unpacking
    // ==========================================================
    assign ccu_word  = beat_i.payload;
    assign knn_word  = beat_i.payload[$bits(ccu_pkg::knn_cfg_t)-1:0];
    assign sya_word0 = beat_i.payload[$bits(ccu_pkg::sya_word0_t)-1:0];
    assign sya_word1 = beat_i.payload[$bits(ccu_pkg::sya_word1_t)-1:0];

    assign is_ccu = beat_vld_i && (beat_i.opcode == ccu_pkg::OP_CCU);
    assign is_knn = beat_vld_i && (beat_i.opcode == ccu_pkg::OP_KNN);
    assign is_sya = beat_vld_i && (beat_i.opcode == ccu_pkg::OP_SYA);

    // Fields only move while their valid is low
    always_ff @(posedge clk) begin
        if (is_knn) begin
            knn_cfg_o <= knn_word;
        end
        if (is_sya && beat_i.word_idx == 1'b0) begin
            sya_cfg_o.w0 <= sya_word0;
        end
        if (is_sya && beat_i.word_idx == 1'b1) begin
            sya_cfg_o.w1 <= sya_word1;
        end
    end

    // ==========================================================
    // Valids and completion
    // ==========================================================
    assign knn_hs = knn_cfg_vld_o & knn_cfg_rdy_i;
    assign sya_hs = sya_cfg_vld_o & sya_cfg_rdy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_num_layer_o <= '0;
            ccu_done_q      <= 1'b0;
            knn_cfg_vld_o   <= 1'b0;
            sya_cfg_vld_o   <= 1'b0;
        end else begin
            if (is_ccu) begin
                cfg_num_layer_o <= ccu_word.num_layer;
            end
            ccu_done_q <= is_ccu & beat_i.last;   // No consumer, done right away
            if (knn_hs) begin
                knn_cfg_vld_o <= 1'b0;
            end else if (is_knn && beat_i.last) begin
                knn_cfg_vld_o <= 1'b1;
            end
            if (sya_hs) begin
                sya_cfg_vld_o <= 1'b0;
            end else if (is_sya && beat_i.last) begin
                sya_cfg_vld_o <= 1'b1;
            end
        end
    end

    assign cfg_done_o = ccu_done_q | knn_hs | sya_hs;

endmodule

`default_nettype wire

// ==== verilog/ccu_top.sv ====
`default_nettype none

module ccu_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    start_i,
    output logic                         net_done_o,
    output logic                         units_rst_o,

    // Instruction read port of the global buffer
    output logic [ccu_pkg::ADDR_W-1:0]   isa_addr_o,
    output logic                         isa_addr_vld_o,
    input  wire logic                    isa_addr_rdy_i,
    input  wire ccu_pkg::isa_word_t      isa_dat_i,
    input  wire logic                    isa_dat_vld_i,
    output logic                         isa_dat_rdy_o,
    output logic [ccu_pkg::ADDR_W-1:0]   isa_rd_addr_min_o,

    // Unit configuration
    output ccu_pkg::knn_cfg_t            knn_cfg_o,
    output logic                         knn_cfg_vld_o,
    input  wire logic                    knn_cfg_rdy_i,
    output ccu_pkg::sya_cfg_t            sya_cfg_o,
    output logic                         sya_cfg_vld_o,
    input  wire logic                    sya_cfg_rdy_i
);

    logic                            fetch_en;
    ccu_pkg::ccu_opcode_e            sel_unit;
    logic                            units_rst;
    ccu_pkg::isa_beat_t              beat;
    logic                            beat_vld;
    logic                            last_beat;
    logic                            cfg_done;
    logic [ccu_pkg::NUM_LAYER_W-1:0] cfg_num_layer;

    assign last_beat   = beat_vld & beat.last;
    assign units_rst_o = units_rst;

    // ==========================================================
    // Sequencing, fetch and decode
    // ==========================================================
    ccu_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start_i),
        .knn_rdy_i       (knn_cfg_rdy_i),   // Unit readies double as requests
        .sya_rdy_i       (sya_cfg_rdy_i),
        .last_beat_i     (last_beat),
        .cfg_done_i      (cfg_done),
        .cfg_num_layer_i (cfg_num_layer),
        .fetch_en_o      (fetch_en),
        .sel_unit_o      (sel_unit),
        .units_rst_o     (units_rst),
        .net_done_o      (net_done_o)
    );

    ccu_isa_fetch u_isa_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .fetch_en_i        (fetch_en),
        .sel_unit_i        (sel_unit),
        .clear_i           (units_rst),
        .isa_addr_o        (isa_addr_o),
        .isa_addr_vld_o    (isa_addr_vld_o),
        .isa_addr_rdy_i    (isa_addr_rdy_i),
        .isa_dat_i         (isa_dat_i),
        .isa_dat_vld_i     (isa_dat_vld_i),
        .isa_dat_rdy_o     (isa_dat_rdy_o),
        .beat_o            (beat),
        .beat_vld_o        (beat_vld),
        .isa_rd_addr_min_o (isa_rd_addr_min_o)
    );

    ccu_cfg_decoder u_cfg_decoder (
        .clk             (clk),
        .rst_n           (rst_n),
        .beat_i          (beat),
        .beat_vld_i      (beat_vld),
        .knn_cfg_o       (knn_cfg_o),
        .knn_cfg_vld_o   (knn_cfg_vld_o),
        .knn_cfg_rdy_i   (knn_cfg_rdy_i),
        .sya_cfg_o       (sya_cfg_o),
        .sya_cfg_vld_o   (sya_cfg_vld_o),
        .sya_cfg_rdy_i   (sya_cfg_rdy_i),
        .cfg_num_layer_o (cfg_num_layer),
        .cfg_done_o      (cfg_done)
    );

endmodule

`default_nettype wire

// ==== bench/ccu_chk.sv ====
`default_nettype none

module ccu_chk (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire ccu_pkg::knn_cfg_t knn_cfg_o,
    input wire logic              knn_cfg_vld_o,
    input wire logic              knn_cfg_rdy_i,
    input wire ccu_pkg::sya_cfg_t sya_cfg_o,
    input wire logic              sya_cfg_vld_o,
    input wire logic              sya_cfg_rdy_i,
    input wire logic              net_done_o,
    input wire logic              units_rst_o,
    input wire logic              isa_addr_vld_o,
    input wire logic              isa_dat_rdy_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // ==========================================================
    // Configuration channel
    // ==========================================================
    knn_hold: assert property (@(posedge clk) disable iff (!rst_n)
        knn_cfg_vld_o && !knn_cfg_rdy_i |=> knn_cfg_vld_o && $stable(knn_cfg_o))
        else $error("KNN valid dropped or fields moved");

    sya_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sya_cfg_vld_o && !sya_cfg_rdy_i |=> sya_cfg_vld_o && $stable(sya_cfg_o))
        else $error("SYA valid dropped or fields moved");

    no_vld_in_rst: assert property (@(posedge clk) disable iff (!rst_n)
        units_rst_o |-> !knn_cfg_vld_o && !sya_cfg_vld_o)
        else $error("Config valid while units in reset");

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        net_done_o |=> !net_done_o)
        else $error("net_done_o longer than one cycle");

    one_read: assert property (@(posedge clk) disable iff (!rst_n)
        isa_dat_rdy_o |-> !isa_addr_vld_o)
        else $error("Second read issued while one is pending");

endmodule

bind ccu_top ccu_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .knn_cfg_o      (knn_cfg_o),
    .knn_cfg_vld_o  (knn_cfg_vld_o),
    .knn_cfg_rdy_i  (knn_cfg_rdy_i),
    .sya_cfg_o      (sya_cfg_o),
    .sya_cfg_vld_o  (sya_cfg_vld_o),
    .sya_cfg_rdy_i  (sya_cfg_rdy_i),
    .net_done_o     (net_done_o),
    .units_rst_o    (units_rst_o),
    .isa_addr_vld_o (isa_addr_vld_o),
    .isa_dat_rdy_o  (isa_dat_rdy_o)
);

`default_nettype wire

// ==== bench/tb_ccu.sv ====
`default_nettype none

module tb_ccu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_DEPTH = 8;
    localparam int MAX_CYCLES = 4000;

    logic                       clk;
    logic                       rst_n;
    logic                       start_i;
    logic                       net_done_o;
    logic                       units_rst_o;
    logic [ccu_pkg::ADDR_W-1:0] isa_addr_o;
    logic                       isa_addr_vld_o;
    logic                       isa_addr_rdy_i;
    ccu_pkg::isa_word_t         isa_dat_i;
    logic                       isa_dat_vld_i;
    logic                       isa_dat_rdy_o;
    logic [ccu_pkg::ADDR_W-1:0] isa_rd_addr_min_o;
    ccu_pkg::knn_cfg_t          knn_cfg_o;
    logic                       knn_cfg_vld_o;
    logic                       knn_cfg_rdy_i;
    ccu_pkg::sya_cfg_t          sya_cfg_o;
    logic                       sya_cfg_vld_o;
    logic                       sya_cfg_rdy_i;

    ccu_pkg::isa_word_t   mem [ccu_pkg::NUM_UNIT][MEM_DEPTH];
    int                   consumed [ccu_pkg::NUM_UNIT];
    ccu_pkg::ccu_opcode_e hs_order [$];
    ccu_pkg::knn_cfg_t    knn_exp;
    ccu_pkg::sya_cfg_t    sya_exp [2];
    logic [31:0]          rng_q = 32'd75181;
    logic                 addr_hs_seen;
    logic                 dat_hs_seen;
    logic                 rd_wait;
    logic [1:0]           rd_delay;
    logic [ccu_pkg::ADDR_W-1:0] rd_addr;
    int                   err_cnt = 0;
    int                   chk_cnt = 0;
    int                   cycle_cnt = 0;
    int                   done_pulses = 0;

    ccu_top uut (.*);

    always #4 clk = ~clk;   // 8 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic rand_vec(output logic [191:0] v);
        for (int i = 0; i < 6; i++) begin
            rng_q = xorshift(rng_q);
            v[i*32 +: 32] = rng_q;
        end
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_knn(input string name, input ccu_pkg::knn_cfg_t got,
                             input ccu_pkg::knn_cfg_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sya(input string name, input ccu_pkg::sya_cfg_t got,
                             input ccu_pkg::sya_cfg_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ccu_pkg::ADDR_W-1:0] got,
                              input logic [ccu_pkg::ADDR_W-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ============================================================
    // Timeout
    // ============================================================
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    // ============================================================
    // Instruction memory model
    // ============================================================
    always @(negedge clk) begin
        addr_hs_seen = isa_addr_vld_o && isa_addr_rdy_i;
        dat_hs_seen  = isa_dat_vld_i && isa_dat_rdy_o;
        if (addr_hs_seen) begin
            rd_addr = isa_addr_o;
        end
        if (net_done_o) begin
            done_pulses++;
        end
    end

    always @(posedge clk) begin
        int u;
        int w;
        #1;
        rng_q = xorshift(rng_q);
        isa_addr_rdy_i = rng_q[4];
        if (dat_hs_seen) begin
            isa_dat_vld_i = 1'b0;
        end
        if (addr_hs_seen) begin
            rng_q    = xorshift(rng_q);
            rd_delay = 2'(rng_q % 3);    // 1 to 3 cycles
            rd_wait  = 1'b1;
        end
        if (rd_wait) begin
            if (rd_delay == 0) begin
                u = rd_addr[ccu_pkg::ADDR_W-1 -: ccu_pkg::UNIT_IDX_W];
                w = rd_addr[ccu_pkg::WORD_CNT_W-1:0];
                rd_wait = 1'b0;
                if (u >= ccu_pkg::NUM_UNIT || w >= MEM_DEPTH) begin
                    err_cnt++;
                    $display("Read address %h lies outside the instruction memory", rd_addr);
                end else begin
                    consumed[u]++;
                    isa_dat_i     = mem[u][w];
                    isa_dat_vld_i = 1'b1;
                end
            end else begin
                rd_delay--;
            end
        end
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================
    task automatic fill_memory();
        ccu_pkg::ccu_word_t cw;
        logic [191:0]       v;
        for (int u = 0; u < ccu_pkg::NUM_UNIT; u++) begin
            for (int w = 0; w < MEM_DEPTH; w++) begin
                mem[u][w].opcode  = 8'hee;
                mem[u][w].payload = ccu_pkg::PAYLOAD_W'({u[1:0], w[13:0]} * 16'h9e37);
            end
            consumed[u] = 0;
        end
        cw.pad       = '0;
        cw.num_layer = 20'd2;
        mem[0][0]    = {cw, ccu_pkg::OP_CCU};
        rand_vec(v);
        knn_exp = v[$bits(ccu_pkg::knn_cfg_t)-1:0];
        mem[1][0].payload = '0;
        mem[1][0].payload[$bits(ccu_pkg::knn_cfg_t)-1:0] = knn_exp;
        mem[1][0].opcode = ccu_pkg::OP_KNN;
        mem[2][0].opcode = ccu_pkg::OP_KNN;    // Foreign word in SYA region
        for (int l = 0; l < 2; l++) begin
            rand_vec(v);
            sya_exp[l] = v[$bits(ccu_pkg::sya_cfg_t)-1:0];
            mem[2][1+2*l].payload = '0;
            mem[2][1+2*l].payload[$bits(ccu_pkg::sya_word0_t)-1:0] = sya_exp[l].w0;
            mem[2][1+2*l].opcode  = ccu_pkg::OP_SYA;
            mem[2][2+2*l].payload = '0;
            mem[2][2+2*l].payload[$bits(ccu_pkg::sya_word1_t)-1:0] = sya_exp[l].w1;
            mem[2][2+2*l].opcode  = ccu_pkg::OP_SYA;
        end
    endtask

    // Returns at the negedge before the handshake edge
    task automatic wait_cfg_hs(output ccu_pkg::ccu_opcode_e unit);
        forever begin
            @(negedge clk);
            if (knn_cfg_vld_o && knn_cfg_rdy_i) begin
                unit = ccu_pkg::OP_KNN;
                break;
            end
            if (sya_cfg_vld_o && sya_cfg_rdy_i) begin
                unit = ccu_pkg::OP_SYA;
                break;
            end
        end
        hs_order.push_back(unit);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic test_reset_state();
        @(negedge clk);
        check_bit("net_done_o", net_done_o, 1'b0);
        check_bit("knn_cfg_vld_o", knn_cfg_vld_o, 1'b0);
        check_bit("sya_cfg_vld_o", sya_cfg_vld_o, 1'b0);
        check_bit("isa_addr_vld_o", isa_addr_vld_o, 1'b0);
        check_bit("isa_dat_rdy_o", isa_dat_rdy_o, 1'b0);
        check_bit("units_rst_o", units_rst_o, 1'b1);
    endtask

    task automatic test_network();
        ccu_pkg::ccu_opcode_e unit;
        logic [ccu_pkg::ADDR_W-1:0] min_exp;
        logic [ccu_pkg::ADDR_W-1:0] a;
        fill_memory();
        @(posedge clk);
        #1;
        start_i       = 1'b1;
        knn_cfg_rdy_i = 1'b1;   // KNN wins over SYA
        sya_cfg_rdy_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        wait_cfg_hs(unit);
        check_knn("knn_cfg_o", knn_cfg_o, knn_exp);
        @(posedge clk);
        #1;
        knn_cfg_rdy_i = 1'b0;
        wait_cfg_hs(unit);
        check_sya("sya_cfg_o", sya_cfg_o, sya_exp[0]);
        // Second layer fetch started, then back-pressure it
        do @(negedge clk); while (!isa_addr_vld_o);
        @(posedge clk);
        #1;
        sya_cfg_rdy_i = 1'b0;
        do @(negedge clk); while (!sya_cfg_vld_o);
        repeat (20) begin
            @(negedge clk);
            check_bit("sya_cfg_vld_o", sya_cfg_vld_o, 1'b1);
            check_sya("sya_cfg_o", sya_cfg_o, sya_exp[1]);
        end
        // Lowest consumed address, skipped word counted
        min_exp = '1;
        for (int u = 0; u < ccu_pkg::NUM_UNIT; u++) begin
            a = {u[1:0], 14'(consumed[u])};
            if (a < min_exp) begin
                min_exp = a;
            end
        end
        if (consumed[0] != 1 || consumed[1] != 1 || consumed[2] != 5) begin
            err_cnt++;
            $display("Words read per unit are %0d %0d %0d instead of 1 1 5",
                     consumed[0], consumed[1], consumed[2]);
        end
        check_addr("isa_rd_addr_min_o", isa_rd_addr_min_o, min_exp);
        @(posedge clk);
        #1;
        sya_cfg_rdy_i = 1'b1;
        wait_cfg_hs(unit);
        check_sya("sya_cfg_o", sya_cfg_o, sya_exp[1]);
        @(negedge clk);
        check_bit("net_done_o", net_done_o, 1'b1);
        @(negedge clk);
        check_bit("net_done_o", net_done_o, 1'b0);
        check_bit("units_rst_o", units_rst_o, 1'b1);
        repeat (5) @(negedge clk);
        check_addr("isa_rd_addr_min_o", isa_rd_addr_min_o, '0);
        if (done_pulses != 1) begin
            err_cnt++;
            $display("Network end flagged %0d times instead of once", done_pulses);
        end
        if (hs_order.size() != 3 || hs_order[0] != ccu_pkg::OP_KNN ||
            hs_order[1] != ccu_pkg::OP_SYA || hs_order[2] != ccu_pkg::OP_SYA) begin
            err_cnt++;
            $display("Configurations were delivered in the wrong order");
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        start_i        = 1'b0;
        isa_addr_rdy_i = 1'b0;
        isa_dat_i      = '0;
        isa_dat_vld_i  = 1'b0;
        knn_cfg_rdy_i  = 1'b0;
        sya_cfg_rdy_i  = 1'b0;
        addr_hs_seen   = 1'b0;
        dat_hs_seen    = 1'b0;
        rd_wait        = 1'b0;
        rd_delay       = '0;
        rd_addr        = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        test_network();
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/ccu_pkg.sv
verilog/ccu_sequencer.sv
verilog/ccu_isa_fetch.sv
verilog/ccu_cfg_decoder.sv
verilog/ccu_top.sv
bench/ccu_chk.sv
bench/tb_ccu.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_ccu -Mdir obj_dir -f sim.f

out=$(./obj_dir/Vtb_ccu)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
